//--- Makefile
SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= ps2Keyboard_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Errors found
SOURCES   := $(wildcard src/*.sv src/*.svh verification/*.sv verification/*.txt)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "No errors" $(LOG); then \
	    echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+src
src/ps2Pkg.sv
src/displayPkg.sv
src/ps2Receiver.sv
src/keyStringBuffer.sv
src/displayScanner.sv
src/ps2Keyboard.sv
verification/ps2Keyboard_props.sv
verification/ps2Keyboard_tb.sv

//--- src/displayPkg.sv
`default_nettype none
`include "ps2_settings.svh"

// display side types and the key to glyph table

package displayPkg;

    typedef logic [6:0]             segments;   // {a,b,c,d,e,f,g}, low = lit
    typedef logic [`NUM_DIGITS-1:0] anodes;     // low = digit on

    localparam segments SegOff = 7'b1111111;

    //////////////////////////////////////////////////////////////////////
    // scan code set 2 to seven segment pattern
    //////////////////////////////////////////////////////////////////////
    function automatic segments glyphOf(ps2Pkg::scanCode code);
        case (code)
            // letters
            8'h1c:   glyphOf = 7'b0001000;    // a
            8'h32:   glyphOf = 7'b1100000;    // b
            8'h21:   glyphOf = 7'b0110001;    // c
            8'h23:   glyphOf = 7'b1000010;    // d
            8'h24:   glyphOf = 7'b0110000;    // e
            8'h2b:   glyphOf = 7'b0111000;    // f
            8'h34:   glyphOf = 7'b0100000;    // g
            8'h33:   glyphOf = 7'b1001000;    // h
            8'h43:   glyphOf = 7'b1111001;    // i
            8'h4b:   glyphOf = 7'b1110001;    // l
            8'h3a:   glyphOf = 7'b0001001;    // m
            8'h31:   glyphOf = 7'b1101010;    // n
            8'h44:   glyphOf = 7'b1100010;    // o
            8'h4d:   glyphOf = 7'b0011000;    // p
            8'h15:   glyphOf = 7'b0001100;    // q
            8'h2d:   glyphOf = 7'b1111010;    // r
            8'h1b:   glyphOf = 7'b0100100;    // s, same as 5
            8'h2c:   glyphOf = 7'b1110000;    // t
            8'h3c:   glyphOf = 7'b1000001;    // u
            8'h2a:   glyphOf = 7'b1100011;    // v
            8'h1a:   glyphOf = 7'b0010010;    // z, same as 2
            // digits on the top row
            8'h45:   glyphOf = 7'b0000001;    // 0
            8'h16:   glyphOf = 7'b1001111;    // 1
            8'h1e:   glyphOf = 7'b0010010;    // 2
            8'h26:   glyphOf = 7'b0000110;    // 3
            8'h25:   glyphOf = 7'b1001100;    // 4
            8'h2e:   glyphOf = 7'b0100100;    // 5
            8'h36:   glyphOf = 7'b0100000;    // 6
            8'h3d:   glyphOf = 7'b0001111;    // 7
            8'h3e:   glyphOf = 7'b0000000;    // 8
            8'h46:   glyphOf = 7'b0000100;    // 9
            default: glyphOf = SegOff;        // no glyph, blank
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/displayScanner.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

// time multiplexed drive of the eight seven-segment digits

module displayScanner (
    input  wire logic                  ck,
    input  wire logic                  reset,
    input  wire ps2Pkg::scanCode       chars [`NUM_DIGITS],
    input  wire logic [`NUM_DIGITS-1:0] filled,
    output displayPkg::anodes          anode,
    output displayPkg::segments        segment
);

    localparam int DivW   = $clog2(`SCAN_CYCLES + 1);
    localparam int DigitW = $clog2(`NUM_DIGITS);

    logic [DivW-1:0]   divCount;
    logic [DigitW-1:0] digit;
    logic              refresh;
    ps2Pkg::scanCode   current;

    //////////////////////////////////////////////////////////////////////
    // refresh divider and digit select
    //////////////////////////////////////////////////////////////////////
    assign refresh = divCount == DivW'(`SCAN_CYCLES - 1);

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            divCount <= '0;
        end else if (refresh) begin
            divCount <= '0;
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            digit <= '0;
        end else if (refresh) begin
            if (digit == DigitW'(`NUM_DIGITS - 1))
                digit <= '0;                 // wrap back to the newest key
            else
                digit <= digit + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    // one hot low on the selected anode
    assign anode = ~(displayPkg::anodes'(1) << digit);

    assign current = chars[digit];

    always_comb begin
        if (filled[digit])
            segment = displayPkg::glyphOf(current);
        else
            segment = displayPkg::SegOff;    // empty digit stays dark
    end

endmodule

`default_nettype wire

//--- src/keyStringBuffer.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

// last NUM_DIGITS keys as a string, digit 0 is the newest

module keyStringBuffer (
    input  wire ps2Pkg::keyEvent   rxEvent,
    input  wire logic              ck,
    input  wire logic              reset,
    output ps2Pkg::scanCode        chars [`NUM_DIGITS],
    output logic [`NUM_DIGITS-1:0] filled
);

    localparam int IdleW = $clog2(`PS2_IDLE_CYCLES + 1);

    logic [IdleW-1:0] idleCount;
    logic             idleHit;

    //////////////////////////////////////////////////////////////////////
    // idle timer, saturates once the gap is long enough
    //////////////////////////////////////////////////////////////////////
    assign idleHit = idleCount == IdleW'(`PS2_IDLE_CYCLES);

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            idleCount <= '0;
        end else if (rxEvent.valid) begin
            idleCount <= '0;                  // restart on every key
        end else if (!idleHit) begin
            idleCount <= idleCount + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // string storage
    //////////////////////////////////////////////////////////////////////

    // occupancy, bad frames never reach here since valid stays low
    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            filled <= '0;
        end else if (rxEvent.valid) begin
            if (idleHit)
                filled <= `NUM_DIGITS'(1);    // fresh string, only the new key
            else
                filled <= {filled[`NUM_DIGITS-2:0], 1'b1};
        end
    end

    // characters move up one digit per key, oldest falls off the end
    always_ff @(posedge ck) begin
        if (rxEvent.valid) begin
            chars[0] <= rxEvent.code;
            for (int i = 1; i < `NUM_DIGITS; i++) begin
                chars[i] <= chars[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ps2Keyboard.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

// keyboard to display top level

module ps2Keyboard (
    input  wire logic           ck,
    input  wire logic           reset,
    input  wire logic           ps2Clk,
    input  wire logic           ps2Data,
    output displayPkg::anodes   anode,
    output displayPkg::segments segment,
    output ps2Pkg::scanCode     keyCode,
    output logic                keyValid,
    output logic                keyError
);

    ps2Pkg::keyEvent        rxEvent;
    ps2Pkg::scanCode        chars [`NUM_DIGITS];
    logic [`NUM_DIGITS-1:0] filled;

    ps2Receiver rx0 (
        .ck      (ck),
        .reset   (reset),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .rxEvent (rxEvent)
    );

    keyStringBuffer buf0 (
        .rxEvent (rxEvent),
        .ck      (ck),
        .reset   (reset),
        .chars   (chars),
        .filled  (filled)
    );

    displayScanner scan0 (
        .ck      (ck),
        .reset   (reset),
        .chars   (chars),
        .filled  (filled),
        .anode   (anode),
        .segment (segment)
    );

    // raw key strobes out for status LEDs
    assign keyCode  = rxEvent.code;
    assign keyValid = rxEvent.valid;
    assign keyError = rxEvent.error;

endmodule

`default_nettype wire

//--- src/ps2Pkg.sv
`default_nettype none

// protocol side types: frame layout, received key and receiver FSM

package ps2Pkg;

    // one keyboard make/break code
    typedef logic [7:0] scanCode;

    // frame as it sits in the receiver shift register after all bits
    // have been shifted in from the top, first bit ends up in bit 0
    typedef struct packed {
        logic    stop;       // must be 1
        logic    parity;     // odd over data and parity
        scanCode data;       // LSB first on the wire
        logic    start;      // must be 0
    } ps2Frame;

    // result of one frame, valid and error are single cycle strobes
    typedef struct packed {
        scanCode code;
        logic    valid;
        logic    error;
    } keyEvent;

    // receiver FSM
    typedef enum logic [2:0] {
        Idle,                // waiting for start condition
        Delay,               // settling time after falling edge
        SaveBit,             // shift one bit in
        ClockLow,            // wait for keyboard clock to rise
        ClockHigh,           // wait for next fall, or time out
        Done                 // report frame
    } rxState;

endpackage

`default_nettype wire

//--- src/ps2Receiver.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

// device to host PS/2 receiver, one keyEvent per complete frame

module ps2Receiver (
    input  wire logic       ck,
    input  wire logic       reset,
    input  wire logic       ps2Clk,
    input  wire logic       ps2Data,
    output ps2Pkg::keyEvent rxEvent
);

    localparam int DelayW   = $clog2(`PS2_SAMPLE_DELAY + 1);
    localparam int TimeoutW = $clog2(`PS2_FRAME_TIMEOUT + 1);
    localparam int BitW     = $clog2(`FRAME_BITS + 1);

    logic [1:0]          clkSync;
    logic [1:0]          dataSync;
    logic                clkPrev;
    logic                clkS;
    logic                dataS;
    logic                clkFall;
    ps2Pkg::rxState      state;
    ps2Pkg::rxState      stateNxt;
    logic [DelayW-1:0]   delayCount;
    logic [TimeoutW-1:0] timeoutCount;
    logic [BitW-1:0]     bitCount;
    ps2Pkg::ps2Frame     frame;
    logic                delayHit;
    logic                timeoutHit;
    logic                lastBit;
    logic                frameOk;

    //////////////////////////////////////////////////////////////////////
    // line synchronizers, both lines idle high
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            clkSync  <= 2'b11;
            dataSync <= 2'b11;
            clkPrev  <= 1'b1;
        end else begin
            clkSync  <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkPrev  <= clkSync[1];
        end
    end

    assign clkS    = clkSync[1];
    assign dataS   = dataSync[1];
    assign clkFall = clkPrev & ~clkS;

    assign delayHit   = delayCount == DelayW'(`PS2_SAMPLE_DELAY - 1);
    assign timeoutHit = timeoutCount == TimeoutW'(`PS2_FRAME_TIMEOUT - 1);
    assign lastBit    = bitCount == BitW'(`FRAME_BITS - 1);   // storing the stop bit

    //////////////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        stateNxt = state;
        case (state)
            ps2Pkg::Idle:
                if (clkFall && !dataS)
                    stateNxt = ps2Pkg::Delay;     // start bit seen
            ps2Pkg::Delay:
                if (delayHit)
                    stateNxt = ps2Pkg::SaveBit;
            ps2Pkg::SaveBit:
                stateNxt = lastBit ? ps2Pkg::Done : ps2Pkg::ClockLow;
            ps2Pkg::ClockLow:
                if (clkS)
                    stateNxt = ps2Pkg::ClockHigh;
            ps2Pkg::ClockHigh:
                if (timeoutHit)
                    stateNxt = ps2Pkg::Idle;      // keyboard gave up, drop it
                else if (!clkS)
                    stateNxt = ps2Pkg::Delay;
            ps2Pkg::Done:
                stateNxt = ps2Pkg::Idle;
            default:
                stateNxt = ps2Pkg::Idle;
        endcase
    end

    always_ff @(posedge ck or posedge reset) begin
        if (reset) begin
            state        <= ps2Pkg::Idle;
            delayCount   <= '0;
            timeoutCount <= '0;
            bitCount     <= '0;
        end else begin
            state        <= stateNxt;
            delayCount   <= (state == ps2Pkg::Delay) ? delayCount + 1'b1 : '0;
            timeoutCount <= (state == ps2Pkg::ClockHigh) ? timeoutCount + 1'b1 : '0;
            if (state == ps2Pkg::Idle)
                bitCount <= '0;
            else if (state == ps2Pkg::SaveBit)
                bitCount <= bitCount + 1'b1;
        end
    end

    // new bit enters at the top, start bit lands in bit 0
    always_ff @(posedge ck) begin
        if (state == ps2Pkg::SaveBit)
            frame <= {dataS, frame[$bits(frame)-1:1]};
    end

    // start low, stop high, odd parity over data plus parity bit
    assign frameOk = !frame.start && frame.stop && (^{frame.data, frame.parity});

    always_comb begin
        rxEvent.code  = frame.data;
        rxEvent.valid = (state == ps2Pkg::Done) && frameOk;
        rxEvent.error = (state == ps2Pkg::Done) && !frameOk;
    end

endmodule

`default_nettype wire

//--- src/ps2_settings.svh
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// PS/2 receiver timing, counted in system clock cycles
//////////////////////////////////////////////////////////////////////

// wait after a falling keyboard clock before the data bit is taken
`define PS2_SAMPLE_DELAY 130

// high keyboard clock longer than this drops a partial frame
`define PS2_FRAME_TIMEOUT 3700

// quiet time after which the next key starts a fresh string
// (about 5 s on the board, scaled down here)
`define PS2_IDLE_CYCLES 20000

//////////////////////////////////////////////////////////////////////
// display and frame geometry
//////////////////////////////////////////////////////////////////////

`define SCAN_CYCLES 16        // cycles each digit stays lit
`define NUM_DIGITS  8         // digits on the board
`define FRAME_BITS  11        // start, 8 data, parity, stop

`endif

//--- verification/ps2Keyboard_props.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

// receiver strobe spacing and anode scan order for binding into the DUT

module ps2Keyboard_props #(
    parameter bit EventChecks = 1'b1,
    parameter bit AnodeChecks = 1'b1
) (
    input wire logic                   ck,
    input wire logic                   reset,
    input wire logic                   valid,
    input wire logic                   error,
    input wire logic [`NUM_DIGITS-1:0] anode
);

    localparam int MinGap = `FRAME_BITS * `PS2_SAMPLE_DELAY;   // shortest possible frame

    int failCount = 0;    // failed assertions so far

    if (EventChecks) begin : eventProps
        int sinceStrobe;    // cycles since the last strobe, saturating

        always_ff @(posedge ck or posedge reset) begin
            if (reset)
                sinceStrobe <= MinGap;
            else if (valid || error)
                sinceStrobe <= 0;
            else if (sinceStrobe < MinGap)
                sinceStrobe <= sinceStrobe + 1;
        end

        // a single one-cycle strobe per frame, never both kinds at once
        assert property (@(posedge ck) disable iff (reset)
            (valid || error) |-> (valid != error) && sinceStrobe >= MinGap)
            else begin
                $error("keyValid or keyError not a single strobe per frame");
                failCount++;
            end
    end

    if (AnodeChecks) begin : anodeProps
        // one digit lit, either held or stepped on to the next digit
        assert property (@(posedge ck) disable iff (reset)
            $onehot(~anode)
            && ($stable(anode) || anode == {$past(anode[`NUM_DIGITS-2:0]),
                                            $past(anode[`NUM_DIGITS-1])}))
            else begin
                $error("anode not one-hot or digits not scanned in order");
                failCount++;
            end
    end

endmodule

`default_nettype wire

//--- verification/ps2Keyboard_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "ps2_settings.svh"

module ps2Keyboard_tb;

    localparam int HalfBit     = 2 * `PS2_SAMPLE_DELAY;    // keyboard clock half period
    localparam int FrameCycles = `FRAME_BITS * (2 * HalfBit + 1) + 1;
    localparam int MaxTests    = 64;

    logic                   ck;
    logic                   reset;
    logic                   ps2Clk;
    logic                   ps2Data;
    logic [`NUM_DIGITS-1:0] anode;
    logic [6:0]             segment;
    logic [7:0]             keyCode;
    logic                   keyValid;
    logic                   keyError;

    logic [7:0]             testMem [4*MaxTests];    // kind, code, flag, glyph
    logic [6:0]             expGlyph [`NUM_DIGITS];   // model of the string, digit 0 newest
    logic [`NUM_DIGITS-1:0] expFilled;
    logic [31:0]            seed;
    logic [7:0]             lastCode;
    bit                     testsLoaded;
    int                     numTests;
    int                     errors;
    int                     passed;
    int                     validCount;
    int                     errorCount;
    int                     sinceValid;
    int                     gapAtValid;

    ps2Keyboard dut0 (
        .ck       (ck),
        .reset    (reset),
        .ps2Clk   (ps2Clk),
        .ps2Data  (ps2Data),
        .anode    (anode),
        .segment  (segment),
        .keyCode  (keyCode),
        .keyValid (keyValid),
        .keyError (keyError)
    );

    bind ps2Receiver ps2Keyboard_props #(.AnodeChecks(1'b0)) rxProps (
        .ck    (ck),
        .reset (reset),
        .valid (rxEvent.valid),
        .error (rxEvent.error),
        .anode ('1)
    );

    bind displayScanner ps2Keyboard_props #(.EventChecks(1'b0)) scanProps (
        .ck    (ck),
        .reset (reset),
        .valid (1'b0),
        .error (1'b0),
        .anode (anode)
    );

    initial begin
        ck = 1'b0;
        forever #50 ck = ~ck;
    end

    // strobe counter, also measures the gap between keys
    always @(posedge ck) begin
        if (reset) begin
            sinceValid = 0;
        end else begin
            if (keyValid) begin
                validCount = validCount + 1;
                gapAtValid = sinceValid;
                lastCode   = keyCode;
                sinceValid = 0;
            end else begin
                sinceValid = sinceValid + 1;
            end
            if (keyError)
                errorCount = errorCount + 1;
        end
    end

    initial begin
        wait (testsLoaded);
        repeat (numTests * (2 * FrameCycles + `PS2_FRAME_TIMEOUT + `PS2_IDLE_CYCLES + 1500
                + 4 * `NUM_DIGITS * `SCAN_CYCLES) + 1000) @(posedge ck);
        $display("watchdog: the tests did not finish in time, run stopped");
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // index of the single low anode, -1 if not exactly one
    function automatic int lowIndex(input logic [`NUM_DIGITS-1:0] a);
        int idx;
        int lows;
        idx  = -1;
        lows = 0;
        for (int i = 0; i < `NUM_DIGITS; i++) begin
            if (a[i] == 1'b0) begin
                idx = i;
                lows++;
            end
        end
        return (lows == 1) ? idx : -1;
    endfunction

    // device to host frame, data changes while the keyboard clock is high
    task automatic sendFrame(input logic [7:0] code, input logic badParity, input int nBits);
        logic [10:0] bits;
        bits = {1'b1, (~^code) ^ badParity, code, 1'b0};   // stop, odd parity, data, start
        for (int i = 0; i < nBits; i++) begin
            @(posedge ck);
            ps2Data <= bits[i];
            repeat (HalfBit / 2) @(posedge ck);
            ps2Clk <= 1'b0;
            repeat (HalfBit) @(posedge ck);
            ps2Clk <= 1'b1;
            repeat (HalfBit / 2) @(posedge ck);
        end
        @(posedge ck);
        ps2Data <= 1'b1;                                   // line back to idle
    endtask

    // follow the scan over all digits and compare each with the model
    task automatic checkDisplay(input int t, output int bad);
        logic [`NUM_DIGITS-1:0] prev;
        logic [6:0]             want;
        int                     seen;
        int                     n;
        int                     d;
        bad  = 0;
        seen = 0;
        n    = 0;
        @(negedge ck);
        prev = anode;
        while (seen < `NUM_DIGITS && n < 4 * `NUM_DIGITS * `SCAN_CYCLES) begin
            @(negedge ck);
            n++;
            if (anode != prev) begin
                prev = anode;
                seen++;
                d    = lowIndex(anode);
                want = (d >= 0 && expFilled[d]) ? expGlyph[d] : 7'h7f;   // blank when empty
                if (d < 0 || segment !== want) begin
                    $display("FAIL at %0t: test %0d anode %b shows %b, expected %b",
                             $time, t, anode, segment, want);
                    bad++;
                end
            end
        end
        if (seen < `NUM_DIGITS) begin
            $display("test %0d: the display stopped scanning", t);
            bad++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        int         bad;
        int         dispBad;
        int         v0;
        int         e0;
        int         n;
        logic [7:0] kind;
        logic [7:0] code;
        logic [7:0] flag;
        logic [6:0] glyph;
        reset      <= 1'b1;
        ps2Clk     <= 1'b1;
        ps2Data    <= 1'b1;
        errors     = 0;
        passed     = 0;
        validCount = 0;
        errorCount = 0;
        expFilled  = '0;
        seed       = 32'h6e11_f492;
        $readmemh("verification/ps2Keyboard_tests.txt", testMem);
        numTests = 0;
        while (numTests < MaxTests && testMem[4*numTests] inside {8'h01, 8'h02, 8'h03, 8'h04})
            numTests++;
        testsLoaded = 1'b1;
        repeat (8) @(posedge ck);
        reset <= 1'b0;
        checkDisplay(0, bad);
        $display("reset state: %s", (bad == 0) ? "pass" : "fail");
        errors += bad;

        for (int t = 1; t <= numTests; t++) begin
            kind  = testMem[4*t-4];
            code  = testMem[4*t-3];
            flag  = testMem[4*t-2];
            glyph = testMem[4*t-1][6:0];
            bad   = 0;
            if (kind == 8'h04) begin
                seed = xorshift(seed);
                repeat (`PS2_IDLE_CYCLES + 500 + int'(seed % 1000)) @(posedge ck);
            end
            if (kind == 8'h03) begin
                v0 = validCount + errorCount;
                sendFrame(code, 1'b0, 4);                  // keyboard quits after 4 bits
                repeat (`PS2_FRAME_TIMEOUT + HalfBit) @(negedge ck);
                if (validCount + errorCount != v0) begin
                    $display("FAIL at %0t: test %0d truncated frame gave a pulse", $time, t);
                    bad++;
                end
            end
            v0 = validCount;
            e0 = errorCount;
            sendFrame(code, kind == 8'h02, `FRAME_BITS);
            n = 0;
            do begin
                @(negedge ck);
                n++;
            end while (validCount == v0 && errorCount == e0 && n < 2 * HalfBit);
            if (validCount == v0 && errorCount == e0) begin
                $display("test %0d: no keyValid or keyError pulse after the frame", t);
                bad++;
            end else if (validCount - v0 != int'(flag == 8'h01)
                         || errorCount - e0 != int'(flag == 8'h00)) begin
                $display("FAIL at %0t: test %0d got %0d valid and %0d error pulses",
                         $time, t, validCount - v0, errorCount - e0);
                bad++;
            end else if (flag == 8'h01 && lastCode !== code) begin
                $display("FAIL at %0t: test %0d keyCode %h, expected %h", $time, t, lastCode, code);
                bad++;
            end
            if (flag == 8'h01) begin
                if (gapAtValid > `PS2_IDLE_CYCLES)
                    expFilled = '0;                        // long gap starts a new string
                for (int i = `NUM_DIGITS - 1; i > 0; i--)
                    expGlyph[i] = expGlyph[i-1];
                expGlyph[0] = glyph;
                expFilled   = {expFilled[`NUM_DIGITS-2:0], 1'b1};
            end
            checkDisplay(t, dispBad);
            bad += dispBad;
            $display("test %0d kind %0d code %h: %s", t, kind, code, (bad == 0) ? "pass" : "fail");
            if (bad == 0)
                passed++;
            errors += bad;
        end

        if (numTests == 0) begin
            $display("no tests could be read from the test file");
            errors++;
        end
        errors += dut0.rx0.rxProps.failCount + dut0.scan0.scanProps.failCount;
        $display("%0d tests, %0d passed, %0d failed, %0d errors in total",
                 numTests, passed, numTests - passed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/ps2Keyboard_tests.txt
// kind code flag glyph, all hex; kind 1 good frame, 2 bad parity, 3 cut frame then good, 4 idle gap then good
// flag 1 expects keyValid, 0 expects keyError; glyph is the segment pattern {a..g}, low lit, 7f blank
01 1c 01 08
01 32 01 60
01 21 01 31
02 45 00 01
01 45 01 01
01 16 01 4f
01 76 01 7f
03 1e 01 12
01 24 01 30
01 33 01 48
04 3e 01 00
01 44 01 62
02 4b 00 71
01 f0 01 7f
03 4b 01 71
00 00 00 00
